// ==== common/edgeDetect_config.svh ====
`ifndef EDGE_DETECT_CONFIG_SVH
`define EDGE_DETECT_CONFIG_SVH

// instruction ID answered when the top level is not overridden
`define EDGE_CI_ID_DEFAULT 8'd0

// window geometry
`define EDGE_ROW_WIDTH 8
`define EDGE_ROWS 3
`define EDGE_WINDOW_PIXELS (`EDGE_ROWS * `EDGE_ROW_WIDTH)
`define EDGE_KERNELS 4

// flag positions inside valueB
`define EDGE_REVERSE_BIT 16
`define EDGE_START_BIT 17

`endif

// ==== common/edgeDetectPkg.sv ====
`include "edgeDetect_config.svh"

package edgeDetectPkg;

    // one grey-scale pixel
    typedef logic [7:0] pixelT;

    // action codes carried in valueB[7:0] when the compute flag is clear
    // codes 7 and up are accepted but do nothing
    typedef enum logic [7:0] {
        loadSlot0    = 8'd0,
        loadSlot1    = 8'd1,
        loadSlot2    = 8'd2,
        loadSlot3    = 8'd3,
        loadSlot4    = 8'd4,
        loadSlot5    = 8'd5,
        setThreshold = 8'd6
    } commandT;

    // slot s covers pixels 4s to 4s+3, row r is slots 2r and 2r+1
    typedef logic [2:0] loadSlotT;

    // kernel k lands in byte k
    typedef pixelT [`EDGE_KERNELS-1:0] edgeWordT;

endpackage

// ==== edgeEngine/pixelWindow.sv ====
`timescale 1ns/1ps
`include "edgeDetect_config.svh"

module pixelWindow
    import edgeDetectPkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        loadEnable,
    input  logic        thresholdEnable,
    input  loadSlotT    loadSlot,
    input  logic [31:0] loadData,
    output pixelT       windowPixels [0:`EDGE_WINDOW_PIXELS-1],
    output pixelT       threshold
);

    // ====================
    // pixel store
    // ====================

    // pixel index is {slot, byte}, so byte b of loadData goes to 4*slot + b
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int p = 0; p < `EDGE_WINDOW_PIXELS; p++) begin
                windowPixels[p] <= '0;
            end
        end else if (loadEnable) begin
            for (int b = 0; b < 4; b++) begin
                windowPixels[{loadSlot, 2'(b)}] <= loadData[8*b +: 8];
            end
        end
    end

    // ====================
    // threshold register
    // ====================

    always_ff @(posedge clock) begin
        if (reset) begin
            threshold <= '0;
        end else if (thresholdEnable) begin
            threshold <= loadData[7:0];
        end
    end

endmodule

// ==== edgeEngine/sobelKernel.sv ====
`timescale 1ns/1ps

module sobelKernel
    import edgeDetectPkg::*;
(
    input  pixelT window [0:8],
    input  pixelT threshold,
    output pixelT edgeValue
);

    // each weighted sum is at most 4 * 255, so 10 bits hold it
    logic [9:0]         gxRight;
    logic [9:0]         gxLeft;
    logic [9:0]         gyBottom;
    logic [9:0]         gyTop;
    logic signed [10:0] gx;
    logic signed [10:0] gy;
    logic [9:0]         absGx;
    logic [9:0]         absGy;
    logic [10:0]        magnitude;
    pixelT              saturated;

    // window is taken row by row, p0 top left to p8 bottom right
    assign gxRight  = {2'b0, window[2]} + {1'b0, window[5], 1'b0} + {2'b0, window[8]};
    assign gxLeft   = {2'b0, window[0]} + {1'b0, window[3], 1'b0} + {2'b0, window[6]};
    assign gyBottom = {2'b0, window[6]} + {1'b0, window[7], 1'b0} + {2'b0, window[8]};
    assign gyTop    = {2'b0, window[0]} + {1'b0, window[1], 1'b0} + {2'b0, window[2]};

    assign gx = $signed({1'b0, gxRight}) - $signed({1'b0, gxLeft});
    assign gy = $signed({1'b0, gyBottom}) - $signed({1'b0, gyTop});

    assign absGx = gx[10] ? 10'(-gx) : 10'(gx);
    assign absGy = gy[10] ? 10'(-gy) : 10'(gy);

    assign magnitude = {1'b0, absGx} + {1'b0, absGy};

    // clip to the pixel range
    assign saturated = (magnitude > 11'd255) ? 8'hff : magnitude[7:0];

    // only edges strictly above the threshold survive
    assign edgeValue = (saturated > threshold) ? saturated : '0;

endmodule

// ==== edgeEngine/sobelArray.sv ====
`timescale 1ns/1ps
`include "edgeDetect_config.svh"

module sobelArray
    import edgeDetectPkg::*;
(
    input  pixelT    windowPixels [0:`EDGE_WINDOW_PIXELS-1],
    input  pixelT    threshold,
    input  logic     reverse,
    output edgeWordT edgeWord
);

    localparam int rowWidth  = `EDGE_ROW_WIDTH;
    localparam int halfShift = `EDGE_ROW_WIDTH / 2;

    pixelT rotated [0:`EDGE_WINDOW_PIXELS-1];

    // ====================
    // column rotation
    // ====================

    // with reverse set, column c of each row reads stored column (c+4) mod 8
    for (genvar p = 0; p < `EDGE_WINDOW_PIXELS; p++) begin : gRotate
        localparam int row    = p / rowWidth;
        localparam int column = p % rowWidth;
        localparam int source = row * rowWidth + (column + halfShift) % rowWidth;

        assign rotated[p] = reverse ? windowPixels[source] : windowPixels[p];
    end

    // ====================
    // kernels
    // ====================

    for (genvar k = 0; k < `EDGE_KERNELS; k++) begin : gKernel
        pixelT kernelWindow [0:8];

        // kernel k covers columns k to k+2 of all three rows
        for (genvar r = 0; r < `EDGE_ROWS; r++) begin : gRow
            for (genvar j = 0; j < 3; j++) begin : gColumn
                assign kernelWindow[r*3 + j] = rotated[r*rowWidth + k + j];
            end
        end

        sobelKernel kernel_i (
            .window    (kernelWindow),
            .threshold (threshold),
            .edgeValue (edgeWord[k])
        );
    end

endmodule

// ==== design/ciDecoder.sv ====
`timescale 1ns/1ps
`include "edgeDetect_config.svh"

module ciDecoder
    import edgeDetectPkg::*;
#(
    parameter logic [7:0] customInstructionId = `EDGE_CI_ID_DEFAULT
) (
    input  logic        start,
    input  logic [7:0]  ciN,
    input  logic [31:0] valueA,
    input  logic [31:0] valueB,
    output logic        loadEnable,
    output logic        thresholdEnable,
    output logic        computeEnable,
    output logic        commandDone,
    output logic        reverse,
    output loadSlotT    loadSlot,
    output logic [31:0] loadData
);

    logic    matched;
    logic    computeFlag;
    commandT command;
    logic    isSlotCode;
    logic    isThresholdCode;

    // a command is ours only in its start cycle and with our ID
    assign matched     = start && (ciN == customInstructionId);
    assign computeFlag = valueB[`EDGE_START_BIT];
    assign command     = commandT'(valueB[7:0]);

    always_comb begin
        isSlotCode      = 1'b0;
        isThresholdCode = 1'b0;
        case (command)
            loadSlot0, loadSlot1, loadSlot2,
            loadSlot3, loadSlot4, loadSlot5: isSlotCode = 1'b1;
            setThreshold:                    isThresholdCode = 1'b1;
            default:                         ;
        endcase
    end

    // a compute never writes, whatever the low byte holds
    assign loadEnable      = matched && !computeFlag && isSlotCode;
    assign thresholdEnable = matched && !computeFlag && isThresholdCode;
    assign computeEnable   = matched && computeFlag;
    assign commandDone     = matched && !computeFlag;

    assign reverse  = valueB[`EDGE_REVERSE_BIT];
    assign loadSlot = loadSlotT'(valueB[2:0]);
    assign loadData = valueA;

endmodule

// ==== design/resultStage.sv ====
`timescale 1ns/1ps

module resultStage
    import edgeDetectPkg::*;
(
    input  logic     clock,
    input  logic     reset,
    input  logic     computeEnable,
    input  logic     commandDone,
    input  edgeWordT edgeWord,
    output logic     done,
    output edgeWordT result
);

    logic     resultValid;
    edgeWordT capturedWord;

    always_ff @(posedge clock) begin
        if (reset) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= computeEnable;
        end
    end

    // sampled in the start cycle so later loads cannot disturb it
    always_ff @(posedge clock) begin
        if (computeEnable) begin
            capturedWord <= edgeWord;
        end
    end

    // a load right after a compute shares the compute's done cycle
    assign done   = commandDone | resultValid;
    assign result = resultValid ? capturedWord : '0;

endmodule

// ==== design/edgeDetectUnit.sv ====
`timescale 1ns/1ps
`include "edgeDetect_config.svh"

module edgeDetectUnit
    import edgeDetectPkg::*;
#(
    parameter logic [7:0] customInstructionId = `EDGE_CI_ID_DEFAULT
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        start,
    input  logic [7:0]  ciN,
    input  logic [31:0] valueA,
    input  logic [31:0] valueB,
    output logic        done,
    output edgeWordT    result
);

    logic        loadEnable;
    logic        thresholdEnable;
    logic        computeEnable;
    logic        commandDone;
    logic        reverse;
    loadSlotT    loadSlot;
    logic [31:0] loadData;
    pixelT       windowPixels [0:`EDGE_WINDOW_PIXELS-1];
    pixelT       threshold;
    edgeWordT    edgeWord;

    // ====================
    // decode
    // ====================

    ciDecoder #(
        .customInstructionId (customInstructionId)
    ) decoder_i (
        .start           (start),
        .ciN             (ciN),
        .valueA          (valueA),
        .valueB          (valueB),
        .loadEnable      (loadEnable),
        .thresholdEnable (thresholdEnable),
        .computeEnable   (computeEnable),
        .commandDone     (commandDone),
        .reverse         (reverse),
        .loadSlot        (loadSlot),
        .loadData        (loadData)
    );

    // ====================
    // execute
    // ====================

    pixelWindow window_i (
        .clock           (clock),
        .reset           (reset),
        .loadEnable      (loadEnable),
        .thresholdEnable (thresholdEnable),
        .loadSlot        (loadSlot),
        .loadData        (loadData),
        .windowPixels    (windowPixels),
        .threshold       (threshold)
    );

    sobelArray array_i (
        .windowPixels (windowPixels),
        .threshold    (threshold),
        .reverse      (reverse),
        .edgeWord     (edgeWord)
    );

    // ====================
    // result
    // ====================

    resultStage result_i (
        .clock         (clock),
        .reset         (reset),
        .computeEnable (computeEnable),
        .commandDone   (commandDone),
        .edgeWord      (edgeWord),
        .done          (done),
        .result        (result)
    );

endmodule

// ==== tb/edgeDetectUnit_checker.sv ====
`timescale 1ns/1ps
`include "edgeDetect_config.svh"

module edgeDetectChecker
    import edgeDetectPkg::*;
#(
    parameter logic [7:0] customInstructionId = `EDGE_CI_ID_DEFAULT
) (
    input logic        clock,
    input logic        reset,
    input logic        start,
    input logic [7:0]  ciN,
    input logic [31:0] valueB,
    input logic        done,
    input edgeWordT    result
);

    logic matched;
    logic matchedCompute;
    logic matchedOther;
    logic computeSeen;

    // number of assertion failures so far
    int   failureCount = 0;

    assign matched        = start && (ciN == customInstructionId);
    assign matchedCompute = matched && valueB[`EDGE_START_BIT];
    assign matchedOther   = matched && !valueB[`EDGE_START_BIT];

    // compute answered in the cycle after its start cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            computeSeen <= 1'b0;
        end else begin
            computeSeen <= matchedCompute;
        end
    end

    // ====================
    // protocol
    // ====================

    resetQuiet: assert property (@(posedge clock) reset |=> (!done && result == '0))
        else begin
            $error("done or result not cleared by reset");
            failureCount++;
        end

    loadDone: assert property (@(posedge clock) disable iff (reset) matchedOther |-> done)
        else begin
            $error("non-compute command got no done in its start cycle");
            failureCount++;
        end

    computeDone: assert property (@(posedge clock) disable iff (reset) matchedCompute |=> done)
        else begin
            $error("compute got no done one cycle after start");
            failureCount++;
        end

    onlyWhenAsked: assert property (@(posedge clock) disable iff (reset)
        done |-> (matchedOther || computeSeen))
        else begin
            $error("done raised without a matching command");
            failureCount++;
        end

    resultIdle: assert property (@(posedge clock) disable iff (reset)
        !computeSeen |-> result == '0)
        else begin
            $error("result nonzero outside a compute answer");
            failureCount++;
        end

endmodule

bind edgeDetectUnit edgeDetectChecker #(
    .customInstructionId (customInstructionId)
) protocolChecker_i (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .ciN    (ciN),
    .valueB (valueB),
    .done   (done),
    .result (result)
);

// ==== tb/edgeDetectUnit_tb.sv ====
`timescale 1ns/1ps
`include "edgeDetect_config.svh"

module edgeDetectUnitTb
    import edgeDetectPkg::*;
();

    localparam logic [7:0] ciId         = `EDGE_CI_ID_DEFAULT;
    localparam logic [7:0] foreignId    = 8'h2a;
    localparam int         resetCycles  = 8;
    localparam int         slotCount    = `EDGE_WINDOW_PIXELS / 4;
    localparam int         randomImages = 40;
    // about ten cycles per random image plus the directed part, with a wide margin
    localparam int         timeoutCycles = (randomImages * 10 + 100) * 4;

    logic        clock = 1'b0;
    logic        reset;
    logic        start;
    logic [7:0]  ciN;
    logic [31:0] valueA;
    logic [31:0] valueB;
    logic        done;
    edgeWordT    result;

    // reference model of window and threshold
    int          modelPixels [0:`EDGE_WINDOW_PIXELS-1];
    int          modelThreshold;
    logic        pendingCompute;
    edgeWordT    pendingWord;
    string       pendingName;
    logic [31:0] imageWords [0:slotCount-1];
    integer      seed = 32'h2562;
    int          cycleCount = 0;
    int          checkCount = 0;
    int          doneErrors = 0;
    int          resultErrors = 0;

    edgeDetectUnit dut_i (
        .clock  (clock),
        .reset  (reset),
        .start  (start),
        .ciN    (ciN),
        .valueA (valueA),
        .valueB (valueB),
        .done   (done),
        .result (result)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > timeoutCycles) begin
            $display("timeout: run did not finish within %0d cycles", timeoutCycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // ====================
    // model
    // ====================

    // window column as the kernels see it, rotated by half a row on reverse
    function automatic int pixelAt(input int row, input int column, input logic rev);
        int stored;
        stored = rev ? (column + `EDGE_ROW_WIDTH / 2) % `EDGE_ROW_WIDTH : column;
        return modelPixels[row * `EDGE_ROW_WIDTH + stored];
    endfunction

    function automatic edgeWordT expectedWord(input logic rev);
        edgeWordT word;
        int       p [0:8];
        int       gx;
        int       gy;
        int       magnitude;
        for (int k = 0; k < `EDGE_KERNELS; k++) begin
            for (int i = 0; i < 9; i++) begin
                p[i] = pixelAt(i / 3, k + i % 3, rev);
            end
            gx = (p[2] + 2 * p[5] + p[8]) - (p[0] + 2 * p[3] + p[6]);
            gy = (p[6] + 2 * p[7] + p[8]) - (p[0] + 2 * p[1] + p[2]);
            magnitude = (gx < 0 ? -gx : gx) + (gy < 0 ? -gy : gy);
            if (magnitude > 255) begin
                magnitude = 255;
            end
            word[k] = (magnitude > modelThreshold) ? 8'(magnitude) : 8'd0;
        end
        return word;
    endfunction

    task automatic applyCommand(input logic [7:0] code, input logic [31:0] data);
        int slot;
        slot = {24'd0, code};
        if (code < 8'd6) begin
            for (int b = 0; b < 4; b++) begin
                modelPixels[slot * 4 + b] = {24'd0, data[8 * b +: 8]};
            end
        end else if (code == 8'd6) begin
            modelThreshold = {24'd0, data[7:0]};
        end
    endtask

    // ====================
    // checks and stimulus
    // ====================

    task automatic checkDone(input string testName, input logic expected);
        checkCount++;
        assert (done === expected) else begin
            $display("FAILED %s: done expected %b, actual %b", testName, expected, done);
            doneErrors++;
        end
    endtask

    task automatic checkResult(input string testName, input edgeWordT expected);
        checkCount++;
        assert (result === expected) else begin
            $display("FAILED %s: result expected %h, actual %h", testName, expected, result);
            resultErrors++;
        end
    endtask

    // one clock cycle, entered and left 1 ns after a rising edge
    task automatic runCycle(input string testName, input logic go, input logic [7:0] id,
                            input logic [31:0] a, input logic [31:0] b);
        logic     matched;
        logic     isCompute;
        edgeWordT computed;
        matched   = go && (id == ciId);
        isCompute = b[`EDGE_START_BIT];
        computed  = expectedWord(b[`EDGE_REVERSE_BIT]);
        start     = go;
        ciN       = id;
        valueA    = a;
        valueB    = b;
        @(negedge clock);
        checkDone(testName, (matched && !isCompute) || pendingCompute);
        if (pendingCompute) begin
            checkResult(pendingName, pendingWord);
        end else begin
            checkResult(testName, '0);
        end
        if (matched && !isCompute) begin
            applyCommand(b[7:0], a);
        end
        pendingCompute = matched && isCompute;
        pendingWord    = computed;
        pendingName    = testName;
        @(posedge clock);
        #1;
    endtask

    task automatic idle(input string testName);
        runCycle(testName, 1'b0, 8'd0, 32'd0, 32'd0);
    endtask

    task automatic loadImage(input string testName);
        for (int s = 0; s < slotCount; s++) begin
            runCycle(testName, 1'b1, ciId, imageWords[s], 32'(s));
        end
    endtask

    task automatic writeThreshold(input string testName, input logic [31:0] data);
        runCycle(testName, 1'b1, ciId, data, 32'd6);
    endtask

    task automatic compute(input string testName, input logic rev);
        logic [31:0] command;
        command = 32'd0;
        command[`EDGE_START_BIT]   = 1'b1;
        command[`EDGE_REVERSE_BIT] = rev;
        runCycle(testName, 1'b1, ciId, 32'd0, command);
    endtask

    task automatic foreignCommand(input string testName, input logic [31:0] a,
                                  input logic [31:0] b);
        runCycle(testName, 1'b1, foreignId, a, b);
    endtask

    initial begin
        int value;
        int protocolErrors;
        reset          = 1'b1;
        start          = 1'b0;
        ciN            = 8'd0;
        valueA         = 32'd0;
        valueB         = 32'd0;
        pendingCompute = 1'b0;
        pendingWord    = '0;
        pendingName    = "";
        modelThreshold = 0;
        for (int p = 0; p < `EDGE_WINDOW_PIXELS; p++) begin
            modelPixels[p] = 0;
        end

        repeat (resetCycles) begin
            @(negedge clock);
            checkDone("reset", 1'b0);
            checkResult("reset", '0);
        end
        @(posedge clock);
        #1;
        reset = 1'b0;
        idle("after reset");
        compute("compute before load", 1'b0);
        idle("compute before load");

        // vertical step at the row middle, lower rows a little brighter
        for (int p = 0; p < `EDGE_WINDOW_PIXELS; p++) begin
            value = 10 * (p / `EDGE_ROW_WIDTH);
            if (p % `EDGE_ROW_WIDTH >= `EDGE_ROW_WIDTH / 2) begin
                value = value + 200;
            end
            imageWords[p / 4][8 * (p % 4) +: 8] = 8'(value);
        end
        loadImage("step load");
        writeThreshold("step threshold", 32'd0);
        idle("step idle");
        compute("step forward", 1'b0);
        idle("step forward");
        compute("step reverse", 1'b1);
        idle("step reverse");
        compute("back to back forward", 1'b0);
        compute("back to back reverse", 1'b1);
        // load merges with the reverse compute's done
        // the flat kernels give exactly 80, so this threshold zeroes them
        writeThreshold("threshold after compute", 32'd80);
        runCycle("unused code", 1'b1, ciId, 32'hffff_ffff, 32'd7);
        idle("unused code");
        compute("step threshold 80", 1'b0);
        idle("step threshold 80");

        foreignCommand("foreign load", 32'hdead_beef, 32'd0);
        foreignCommand("foreign threshold", 32'd0, 32'd6);
        foreignCommand("foreign compute", 32'd0, 32'h0003_0000);
        compute("after foreign", 1'b0);
        idle("after foreign");

        for (int i = 0; i < randomImages; i++) begin
            for (int s = 0; s < slotCount; s++) begin
                imageWords[s] = $random(seed);
            end
            loadImage($sformatf("random %0d load", i));
            writeThreshold($sformatf("random %0d threshold", i), $random(seed));
            compute($sformatf("random %0d forward", i), 1'b0);
            compute($sformatf("random %0d reverse", i), 1'b1);
            idle($sformatf("random %0d idle", i));
        end

        protocolErrors = dut_i.protocolChecker_i.failureCount;
        $display("checks %0d, done errors %0d, result errors %0d, protocol errors %0d",
                 checkCount, doneErrors, resultErrors, protocolErrors);
        if (doneErrors + resultErrors + protocolErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+common
common/edgeDetectPkg.sv
edgeEngine/pixelWindow.sv
edgeEngine/sobelKernel.sv
edgeEngine/sobelArray.sv
design/ciDecoder.sv
design/resultStage.sv
design/edgeDetectUnit.sv
tb/edgeDetectUnit_checker.sv
tb/edgeDetectUnit_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the edge detect testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module edgeDetectUnitTb \
    -Mdir obj_dir \
    -f project.f

output=$(./obj_dir/VedgeDetectUnitTb +verilator+error+limit+1000)
echo "$output"

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
